// ==== debug_stim.txt ====
# pc(hex) p(hex) hst(hex) st(hex) ack_delay(cycles, negative draws 0..7) reset_mid(0/1)
# One record per dump
00000 0 0 0000 0 0
FFFFF F F FFFF 0 0
ABCDE 5 A 8001 1 0
12345 9 5 A5C3 -1 0
0BEEF C 3 1234 12 0
7F00A 1 8 FEDC -1 1
C0DE0 E 6 0F0F 2 0
FACE5 3 C 8421 20 0
9A1B2 B 1 7FFE -1 0

// ==== project.f ====
dbg_pkg.sv
dbg_snapshot.sv
dbg_formatter.sv
dbg_char_out.sv
saturn_debug_top.sv
tb_saturn_debug.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run the testbench and scan the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_saturn_debug \
    -f project.f -o tb_saturn_debug > "$LOG" 2>&1 \
    || { echo "Verilator build failed, see $LOG"; exit 1; }
./obj_dir/tb_saturn_debug >> "$LOG" 2>&1
grep -q "Regression failed" "$LOG" && { echo "Simulation failed, see $LOG"; exit 1; }
grep -q "Regression passed" "$LOG" || { echo "Simulation gave no result, see $LOG"; exit 1; }
echo "Simulation passed"

// ==== tb_saturn_debug.sv ====
`timescale 1ns/1ps

module tb_saturn_debug;

    logic                       i_clk;
    logic                       i_reset;
    logic                       i_phase_last;
    logic                       i_instr_decoded;
    dbg_pkg::dbg_state_t        i_cpu_state;
    logic                       i_char_ack;
    logic [dbg_pkg::CHAR_W-1:0] o_char;
    logic                       o_char_req;
    logic                       o_debug_cycle;

    dbg_pkg::dbg_state_t        rec_state [$];
    int                         rec_delay [$];
    int                         rec_reset [$];
    logic [dbg_pkg::CHAR_W-1:0] exp_text [dbg_pkg::TEXT_LEN];
    int                         exp_len;
    int                         seed;
    int                         cycle_count = 0;
    int                         cycle_limit = 0;

    saturn_debug_top i_dut (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_phase_last    (i_phase_last),
        .i_instr_decoded (i_instr_decoded),
        .i_cpu_state     (i_cpu_state),
        .i_char_ack      (i_char_ack),
        .o_char          (o_char),
        .o_char_req      (o_char_req),
        .o_debug_cycle   (o_debug_cycle)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    always @(posedge i_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            stop_on_error($sformatf("Timeout after %0d cycles, the dumps did not finish",
                                    cycle_count));
        end
    end

    task automatic check_char(input string name, input logic [dbg_pkg::CHAR_W-1:0] got,
                              input logic [dbg_pkg::CHAR_W-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0d ns: %s got 8'h%02h expected 8'h%02h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0d ns: %s got %b expected %b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic append_char(input logic [dbg_pkg::CHAR_W-1:0] ch);
        exp_text[exp_len] = ch;
        exp_len++;
    endtask

    task automatic append_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            append_char(s[i]);
        end
    endtask

    // Two lines: PC in hex, then P, HST bits and ST bits from the MSB down
    task automatic build_expected(input dbg_pkg::dbg_state_t s);
        exp_len = 0;
        append_text("PC: ");
        for (int i = dbg_pkg::PC_W / dbg_pkg::NIBBLE_W - 1; i >= 0; i--) begin
            append_char(dbg_pkg::hex_char(s.pc[i*dbg_pkg::NIBBLE_W +: dbg_pkg::NIBBLE_W]));
        end
        append_char(8'h0A);
        append_text("P: ");
        append_char(dbg_pkg::hex_char(s.p));
        append_text(" HST: ");
        for (int i = dbg_pkg::HST_W - 1; i >= 0; i--) begin
            append_char(s.hst[i] ? 8'h31 : 8'h30);
        end
        append_text(" ST: ");
        for (int i = dbg_pkg::ST_W - 1; i >= 0; i--) begin
            append_char(s.st[i] ? 8'h31 : 8'h30);
        end
        append_char(8'h0A);
    endtask

    task automatic read_stimulus();
        int                           fd;
        int                           n;
        int                           dly;
        int                           rst;
        int                           max_delay;
        int                           dumps;
        string                        line;
        dbg_pkg::dbg_state_t          s;
        logic [dbg_pkg::PC_W-1:0]     pc;
        logic [dbg_pkg::NIBBLE_W-1:0] p;
        logic [dbg_pkg::HST_W-1:0]    hst;
        logic [dbg_pkg::ST_W-1:0]     st;
        max_delay = 7;
        dumps     = 1;
        fd = $fopen("debug_stim.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open the stimulus file debug_stim.txt");
        end
        while ($fgets(line, fd) > 0) begin
            n = $sscanf(line, "%h %h %h %h %d %d", pc, p, hst, st, dly, rst);
            if (n == 6) begin
                s.pc  = pc;
                s.p   = p;
                s.hst = hst;
                s.st  = st;
                rec_state.push_back(s);
                rec_delay.push_back(dly);
                rec_reset.push_back(rst);
                if (dly > max_delay) begin
                    max_delay = dly;
                end
                // An aborted dump is followed by a full one
                dumps += (rst != 0) ? 2 : 1;
            end
        end
        $fclose(fd);
        if (rec_state.size() == 0) begin
            stop_on_error("The stimulus file holds no records");
        end
        cycle_limit = dumps * (dbg_pkg::TEXT_LEN * (max_delay + 4) + 60);
    endtask

    task automatic wait_req(input logic level);
        do begin
            @(posedge i_clk);
            check_flag("o_debug_cycle", o_debug_cycle, 1'b1);
        end while (o_char_req !== level);
    endtask

    // Host side of one four-phase transfer with a chosen acknowledge delay
    task automatic receive_char(input int idx, input int delay_field);
        logic [dbg_pkg::CHAR_W-1:0] held;
        int                         delay;
        wait_req(1'b1);
        held = o_char;
        check_char($sformatf("o_char[%0d]", idx), held, exp_text[idx]);
        delay = (delay_field < 0) ? ($random(seed) & 7) : delay_field;
        repeat (delay) begin
            @(posedge i_clk);
            check_flag("o_char_req", o_char_req, 1'b1);
            check_char("o_char", o_char, held);
        end
        i_char_ack <= 1'b1;
        wait_req(1'b0);
        i_char_ack <= 1'b0;
    endtask

    task automatic trigger_dump(input dbg_pkg::dbg_state_t s);
        @(posedge i_clk);
        i_cpu_state     <= s;
        i_phase_last    <= 1'b1;
        i_instr_decoded <= 1'b1;
        @(posedge i_clk);
        check_flag("o_debug_cycle", o_debug_cycle, 1'b0);
        i_cpu_state     <= ~s;
        i_phase_last    <= 1'b0;
        i_instr_decoded <= 1'b0;
        @(posedge i_clk);
        check_flag("o_debug_cycle", o_debug_cycle, 1'b1);
        // Second trigger with other data lands while busy
        i_phase_last    <= 1'b1;
        i_instr_decoded <= 1'b1;
        @(posedge i_clk);
        i_phase_last    <= 1'b0;
        i_instr_decoded <= 1'b0;
    endtask

    task automatic finish_dump();
        do begin
            @(posedge i_clk);
            check_flag("o_char_req", o_char_req, 1'b0);
        end while (o_debug_cycle);
        repeat (4) begin
            @(posedge i_clk);
            check_flag("o_char_req", o_char_req, 1'b0);
            check_flag("o_debug_cycle", o_debug_cycle, 1'b0);
        end
    endtask

    task automatic reset_mid_stream();
        @(posedge i_clk);
        i_reset    <= 1'b1;
        i_char_ack <= 1'b0;
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
        repeat (3) begin
            check_flag("o_debug_cycle", o_debug_cycle, 1'b0);
            check_flag("o_char_req", o_char_req, 1'b0);
            @(posedge i_clk);
        end
    endtask

    initial begin
        i_reset         = 1'b1;
        i_phase_last    = 1'b0;
        i_instr_decoded = 1'b0;
        i_cpu_state     = '0;
        i_char_ack      = 1'b0;
        seed            = 32'he609b96f;
        read_stimulus();
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
        for (int r = 0; r < rec_state.size(); r++) begin
            build_expected(rec_state[r]);
            trigger_dump(rec_state[r]);
            if (rec_reset[r] != 0) begin
                for (int i = 0; i < 12; i++) begin
                    receive_char(i, rec_delay[r]);
                end
                reset_mid_stream();
                trigger_dump(rec_state[r]);
            end
            for (int i = 0; i < dbg_pkg::TEXT_LEN; i++) begin
                receive_char(i, rec_delay[r]);
            end
            finish_dump();
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== saturn_debug_top.sv ====
`timescale 1ns/1ps

module saturn_debug_top (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_phase_last,
    input  logic                       i_instr_decoded,
    input  dbg_pkg::dbg_state_t        i_cpu_state,
    input  logic                       i_char_ack,
    output logic [dbg_pkg::CHAR_W-1:0] o_char,
    output logic                       o_char_req,
    output logic                       o_debug_cycle
);

    dbg_pkg::dbg_state_t snap_state;
    dbg_pkg::dbg_wr_t    fmt_wr;
    logic                fmt_start;
    logic                send_done;

    // Capture on the last phase of a decoded instruction
    dbg_snapshot u_snapshot (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_phase_last    (i_phase_last),
        .i_instr_decoded (i_instr_decoded),
        .i_cpu_state     (i_cpu_state),
        .i_done          (send_done),
        .o_state         (snap_state),
        .o_start         (fmt_start),
        .o_busy          (o_debug_cycle)
    );

    // Two text lines, one character per cycle
    dbg_formatter u_formatter (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_start (fmt_start),
        .i_state (snap_state),
        .o_wr    (fmt_wr)
    );

    // Buffer and req/ack sender
    dbg_char_out u_char_out (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wr       (fmt_wr),
        .i_char_ack (i_char_ack),
        .o_char     (o_char),
        .o_char_req (o_char_req),
        .o_done     (send_done)
    );

endmodule

// ==== dbg_char_out.sv ====
`timescale 1ns/1ps

module dbg_char_out (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  dbg_pkg::dbg_wr_t             i_wr,
    input  logic                         i_char_ack,
    output logic [dbg_pkg::CHAR_W-1:0]   o_char,
    output logic                         o_char_req,
    output logic                         o_done
);

    logic [dbg_pkg::CHAR_W-1:0] text_buf [dbg_pkg::TEXT_LEN];
    logic [dbg_pkg::ADDR_W-1:0] rd_ptr;
    dbg_pkg::dbg_send_e         state;
    logic                       last_char;

    // Buffer always accepts a write
    always_ff @(posedge i_clk) begin
        if (i_wr.valid) begin
            text_buf[i_wr.addr] <= i_wr.ch;
        end
    end

    assign last_char  = (rd_ptr == dbg_pkg::ADDR_W'(dbg_pkg::TEXT_LEN - 1));
    assign o_char_req = (state == dbg_pkg::SND_REQ);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state  <= dbg_pkg::SND_IDLE;
            rd_ptr <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                dbg_pkg::SND_IDLE: begin
                    // Sending starts once the whole text is in the buffer
                    if (i_wr.valid && i_wr.last) begin
                        o_char <= text_buf[0];
                        rd_ptr <= '0;
                        state  <= dbg_pkg::SND_REQ;
                    end
                end
                dbg_pkg::SND_REQ: begin
                    if (i_char_ack) begin
                        state <= dbg_pkg::SND_WAIT_ACK_LOW;
                    end
                end
                dbg_pkg::SND_WAIT_ACK_LOW: begin
                    if (!i_char_ack) begin
                        if (last_char) begin
                            o_done <= 1'b1;
                            state  <= dbg_pkg::SND_IDLE;
                        end else begin
                            o_char <= text_buf[rd_ptr + 1'b1];
                            rd_ptr <= rd_ptr + 1'b1;
                            state  <= dbg_pkg::SND_REQ;
                        end
                    end
                end
                default: state <= dbg_pkg::SND_IDLE;
            endcase
        end
    end

    // Text must not be overwritten while it is being sent
    a_no_write_while_sending: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_wr.valid |-> (state == dbg_pkg::SND_IDLE)
    );

    // Host keeps ack up until req has dropped
    a_ack_held: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_char_req && i_char_ack) |=> i_char_ack
    );

endmodule

// ==== dbg_formatter.sv ====
`timescale 1ns/1ps

module dbg_formatter (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_start,
    input  dbg_pkg::dbg_state_t i_state,
    output dbg_pkg::dbg_wr_t    o_wr
);

    dbg_pkg::dbg_field_e           field;
    dbg_pkg::dbg_field_e           nxt_field;
    logic [dbg_pkg::PTR_W-1:0]     ptr;
    logic [dbg_pkg::PTR_W-1:0]     nxt_ptr;

    // Character for one field position
    function automatic logic [dbg_pkg::CHAR_W-1:0] field_char(
        input dbg_pkg::dbg_field_e       fld,
        input logic [dbg_pkg::PTR_W-1:0] idx,
        input dbg_pkg::dbg_state_t       s
    );
        logic [dbg_pkg::CHAR_W-1:0] ch;
        int                         pos;
        pos = int'(idx);
        case (fld)
            dbg_pkg::FLD_PC_LABEL:
                ch = dbg_pkg::LBL_PC[(dbg_pkg::LBL_PC_LEN-1-pos)*dbg_pkg::CHAR_W +:
                                     dbg_pkg::CHAR_W];
            dbg_pkg::FLD_PC_HEX:
                ch = dbg_pkg::hex_char(s.pc[pos*dbg_pkg::NIBBLE_W +: dbg_pkg::NIBBLE_W]);
            dbg_pkg::FLD_P_LABEL:
                ch = dbg_pkg::LBL_P[(dbg_pkg::LBL_P_LEN-1-pos)*dbg_pkg::CHAR_W +:
                                    dbg_pkg::CHAR_W];
            dbg_pkg::FLD_P_HEX:
                ch = dbg_pkg::hex_char(s.p);
            dbg_pkg::FLD_HST_LABEL:
                ch = dbg_pkg::LBL_HST[(dbg_pkg::LBL_HST_LEN-1-pos)*dbg_pkg::CHAR_W +:
                                      dbg_pkg::CHAR_W];
            dbg_pkg::FLD_HST_BITS:
                ch = dbg_pkg::hex_char(dbg_pkg::NIBBLE_W'(s.hst[pos]));
            dbg_pkg::FLD_ST_LABEL:
                ch = dbg_pkg::LBL_ST[(dbg_pkg::LBL_ST_LEN-1-pos)*dbg_pkg::CHAR_W +:
                                     dbg_pkg::CHAR_W];
            dbg_pkg::FLD_ST_BITS:
                ch = dbg_pkg::hex_char(dbg_pkg::NIBBLE_W'(s.st[pos]));
            dbg_pkg::FLD_NL0, dbg_pkg::FLD_NL1:
                ch = dbg_pkg::CHAR_NL;
            default:
                ch = dbg_pkg::CHAR_SPACE;
        endcase
        return ch;
    endfunction

    // Labels count up, digits and bits count down from the MSB
    always_comb begin
        nxt_field = field;
        nxt_ptr   = ptr + 1'b1;
        case (field)
            dbg_pkg::FLD_IDLE: begin
                nxt_ptr = '0;
                if (i_start) begin
                    nxt_field = dbg_pkg::FLD_PC_LABEL;
                end
            end
            dbg_pkg::FLD_PC_LABEL: begin
                if (ptr == dbg_pkg::PTR_W'(dbg_pkg::LBL_PC_LEN - 1)) begin
                    nxt_field = dbg_pkg::FLD_PC_HEX;
                    nxt_ptr   = dbg_pkg::PTR_W'(dbg_pkg::PC_W / dbg_pkg::NIBBLE_W - 1);
                end
            end
            dbg_pkg::FLD_PC_HEX: begin
                nxt_ptr = ptr - 1'b1;
                if (ptr == '0) begin
                    nxt_field = dbg_pkg::FLD_NL0;
                end
            end
            dbg_pkg::FLD_NL0: begin
                nxt_field = dbg_pkg::FLD_P_LABEL;
                nxt_ptr   = '0;
            end
            dbg_pkg::FLD_P_LABEL: begin
                if (ptr == dbg_pkg::PTR_W'(dbg_pkg::LBL_P_LEN - 1)) begin
                    nxt_field = dbg_pkg::FLD_P_HEX;
                    nxt_ptr   = '0;
                end
            end
            dbg_pkg::FLD_P_HEX: begin
                nxt_field = dbg_pkg::FLD_HST_LABEL;
                nxt_ptr   = '0;
            end
            dbg_pkg::FLD_HST_LABEL: begin
                if (ptr == dbg_pkg::PTR_W'(dbg_pkg::LBL_HST_LEN - 1)) begin
                    nxt_field = dbg_pkg::FLD_HST_BITS;
                    nxt_ptr   = dbg_pkg::PTR_W'(dbg_pkg::HST_W - 1);
                end
            end
            dbg_pkg::FLD_HST_BITS: begin
                nxt_ptr = ptr - 1'b1;
                if (ptr == '0) begin
                    nxt_field = dbg_pkg::FLD_ST_LABEL;
                    nxt_ptr   = '0;
                end
            end
            dbg_pkg::FLD_ST_LABEL: begin
                if (ptr == dbg_pkg::PTR_W'(dbg_pkg::LBL_ST_LEN - 1)) begin
                    nxt_field = dbg_pkg::FLD_ST_BITS;
                    nxt_ptr   = dbg_pkg::PTR_W'(dbg_pkg::ST_W - 1);
                end
            end
            dbg_pkg::FLD_ST_BITS: begin
                nxt_ptr = ptr - 1'b1;
                if (ptr == '0) begin
                    nxt_field = dbg_pkg::FLD_NL1;
                end
            end
            default: begin
                nxt_field = dbg_pkg::FLD_IDLE;
                nxt_ptr   = '0;
            end
        endcase
    end

    // The registered write always describes the field held in field/ptr
    always_ff @(posedge i_clk) begin
        o_wr.ch   <= field_char(nxt_field, nxt_ptr, i_state);
        o_wr.last <= (nxt_field == dbg_pkg::FLD_NL1);
        if (field == dbg_pkg::FLD_IDLE) begin
            o_wr.addr <= '0;
        end else begin
            o_wr.addr <= o_wr.addr + 1'b1;
        end
        if (i_reset) begin
            field      <= dbg_pkg::FLD_IDLE;
            ptr        <= '0;
            o_wr.valid <= 1'b0;
        end else begin
            field      <= nxt_field;
            ptr        <= nxt_ptr;
            o_wr.valid <= (nxt_field != dbg_pkg::FLD_IDLE);
        end
    end

    // Last flag lands exactly on the final buffer address
    a_last_at_end: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_wr.valid |->
            (o_wr.last == (o_wr.addr == dbg_pkg::ADDR_W'(dbg_pkg::TEXT_LEN - 1)))
    );

endmodule

// ==== dbg_snapshot.sv ====
`timescale 1ns/1ps

module dbg_snapshot (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_phase_last,
    input  logic                i_instr_decoded,
    input  dbg_pkg::dbg_state_t i_cpu_state,
    input  logic                i_done,
    output dbg_pkg::dbg_state_t o_state,
    output logic                o_start,
    output logic                o_busy
);

    logic trigger;

    // Only the end of a decoded instruction counts, and only while idle
    assign trigger = i_phase_last && i_instr_decoded && !o_busy;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_busy  <= 1'b0;
            o_start <= 1'b0;
        end else begin
            o_start <= trigger;
            if (trigger) begin
                o_busy <= 1'b1;
            end else if (i_done) begin
                o_busy <= 1'b0;
            end
        end
    end

    // State is held for the whole dump so the formatter can read it freely
    always_ff @(posedge i_clk) begin
        if (trigger) begin
            o_state <= i_cpu_state;
        end
    end

    // Done only ends a dump that is in progress
    a_done_while_busy: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_done |-> o_busy
    );

endmodule

// ==== dbg_pkg.sv ====
package dbg_pkg;

    // CPU state widths
    localparam int PC_W     = 20;
    localparam int NIBBLE_W = 4;
    localparam int ST_W     = 16;
    localparam int HST_W    = 4;

    // Text buffer geometry
    localparam int CHAR_W   = 8;
    localparam int TEXT_LEN = 46;
    localparam int ADDR_W   = 6;

    // Digit pointer must reach the top ST bit
    localparam int PTR_W    = 4;

    // Fixed labels, first character in the top byte
    localparam int LBL_PC_LEN  = 4;
    localparam int LBL_P_LEN   = 3;
    localparam int LBL_HST_LEN = 6;
    localparam int LBL_ST_LEN  = 5;

    localparam logic [LBL_PC_LEN*CHAR_W-1:0]  LBL_PC  = "PC: ";
    localparam logic [LBL_P_LEN*CHAR_W-1:0]   LBL_P   = "P: ";
    localparam logic [LBL_HST_LEN*CHAR_W-1:0] LBL_HST = " HST: ";
    localparam logic [LBL_ST_LEN*CHAR_W-1:0]  LBL_ST  = " ST: ";

    localparam logic [CHAR_W-1:0] CHAR_NL    = 8'h0A;
    localparam logic [CHAR_W-1:0] CHAR_SPACE = 8'h20;

    // Captured CPU state, 44 bits
    typedef struct packed {
        logic [PC_W-1:0]     pc;
        logic [NIBBLE_W-1:0] p;
        logic [HST_W-1:0]    hst;
        logic [ST_W-1:0]     st;
    } dbg_state_t;

    // One buffer write, 16 bits
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [CHAR_W-1:0] ch;
        logic              last;
    } dbg_wr_t;

    typedef enum logic [3:0] {
        FLD_IDLE,
        FLD_PC_LABEL,
        FLD_PC_HEX,
        FLD_NL0,
        FLD_P_LABEL,
        FLD_P_HEX,
        FLD_HST_LABEL,
        FLD_HST_BITS,
        FLD_ST_LABEL,
        FLD_ST_BITS,
        FLD_NL1
    } dbg_field_e;

    typedef enum logic [1:0] {
        SND_IDLE,
        SND_REQ,
        SND_WAIT_ACK_LOW
    } dbg_send_e;

    // Upper case hex digit
    function automatic logic [CHAR_W-1:0] hex_char(input logic [NIBBLE_W-1:0] nib);
        logic [CHAR_W-1:0] ch;
        if (nib < NIBBLE_W'(10)) begin
            ch = 8'h30 + CHAR_W'(nib);
        end else begin
            ch = 8'h37 + CHAR_W'(nib);
        end
        return ch;
    endfunction

endpackage
